// File: source/regNames.sv
// Register ids are 6 bits; only the low two status bits (T, S) are touched by this execute slice
`default_nettype none

package regNames;

	typedef logic [5:0] gprId;	// GPR id as carried in a micro-op

	// Special register ids
	parameter gprId GR_ZZR = 6'h3F;	// Zero register, writes dropped
	parameter gprId GR_DHR = 6'h01;	// High data register
	parameter gprId GR_LR = 6'h12;	// Link register

	// Flag positions inside the 64-bit status register
	parameter int SR_T = 0;	// Test / carry bit
	parameter int SR_S = 1;	// Sign bit

endpackage

`default_nettype wire

// File: source/execTypes.sv
// Opcode and sub-op encodings are local to this slice; unknown values are treated as NOP downstream
`default_nettype none

package execTypes;

	// Major micro-op opcode
	typedef enum logic [5:0] {
		NOP = 6'h00,
		MOV_IR = 6'h01,	// Imm to Rm
		LEA_MR = 6'h02,	// Rm + Imm to Rm
		ALU3 = 6'h03,
		ALUCMP = 6'h04,	// Flags only
		MULW3 = 6'h05,	// Word multiply, result in EX2
		JMP = 6'h06,
		OP_IXT = 6'h07
	} uCmd;

	// Sub-op, meaning depends on the major opcode
	typedef enum logic [5:0] {
		ADD = 6'h00,
		SUB = 6'h01,
		AND = 6'h02,
		OR = 6'h03,
		XOR = 6'h04,
		CMPEQ = 6'h05,
		CMPGT = 6'h06,	// Signed
		IXT_NOP = 6'h20,
		IXT_SLEEP = 6'h21
	} uIxt;

	typedef struct packed {
		uCmd cmd;
		uIxt ixt;
		regNames::gprId idRs;	// Source A
		regNames::gprId idRt;	// Source B
		regNames::gprId idRm;	// Dest
		logic [32:0] imm;	// Sign-extended on use
	} microOp;

	typedef struct packed {
		regNames::gprId regId;
		logic [63:0] value;
	} writeBack;

	// EX1 register contents handed to EX2
	typedef struct packed {
		microOp op;
		writeBack wb;	// Default writeback formed in EX1
		logic [63:0] aluResult;
		logic [1:0] aluFlags;	// {S, T}
		logic [63:0] valRs;	// Needed for JMP status restore
	} ex1Bundle;

endpackage

`default_nettype wire

// File: source/exAlu.sv
// Purely combinational; unknown sub-ops give a zero result and clear flags
`timescale 1ns/100ps
`default_nettype none

module exAlu (
	input wire execTypes::uIxt ixt,
	input wire [63:0] a,
	input wire [63:0] b,
	output logic [63:0] result,
	output logic [1:0] flags
);

	logic [64:0] sum;	// Carry in top bit
	logic [64:0] diff;	// Borrow in top bit

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = '0;
		flags = '0;
		case (ixt)
			execTypes::ADD: begin
				result = sum[63:0];
				flags[regNames::SR_T] = sum[64];	// Carry out
				flags[regNames::SR_S] = sum[63];
			end
			execTypes::SUB: begin
				result = diff[63:0];
				flags[regNames::SR_T] = diff[64];	// Borrow
				flags[regNames::SR_S] = diff[63];
			end
			execTypes::AND: begin
				result = a & b;
				flags[regNames::SR_S] = result[63];	// T stays clear
			end
			execTypes::OR: begin
				result = a | b;
				flags[regNames::SR_S] = result[63];
			end
			execTypes::XOR: begin
				result = a ^ b;
				flags[regNames::SR_S] = result[63];
			end
			execTypes::CMPEQ: begin
				flags[regNames::SR_T] = (a == b);	// Result left zero
			end
			execTypes::CMPGT: begin
				flags[regNames::SR_T] = ($signed(a) > $signed(b));
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/exMulWord.sv
// Signed 32x32 only; partial products must advance in lockstep with the EX1 register
`timescale 1ns/100ps
`default_nettype none

module exMulWord (
	input wire clock,
	input wire rst,
	input wire advance,	// Low during a pipeline hold
	input wire [31:0] a,
	input wire [31:0] b,
	output logic [63:0] product
);

	logic [31:0] ppLL;	// Unsigned lo x lo
	logic signed [32:0] ppLH;	// Unsigned lo x signed hi
	logic signed [32:0] ppHL;
	logic signed [31:0] ppHH;	// Signed hi x hi
	logic signed [63:0] midSum;

	// Stage A, sits alongside EX1
	always_ff @(posedge clock) begin
		if (rst) begin
			ppLL <= '0;
			ppLH <= '0;
			ppHL <= '0;
			ppHH <= '0;
		end else if (advance) begin
			ppLL <= a[15:0] * b[15:0];
			ppLH <= $signed({1'b0, a[15:0]}) * $signed(b[31:16]);
			ppHL <= $signed(a[31:16]) * $signed({1'b0, b[15:0]});
			ppHH <= $signed(a[31:16]) * $signed(b[31:16]);
		end
	end

	// Stage B, cross terms sign-extended before the shift
	assign midSum = ppLH + ppHL;
	assign product = {ppHH, 32'h0} + (midSum << 16) + {32'h0, ppLL};

endmodule

`default_nettype wire

// File: source/exStage1.sv
// Op and operands must stay stable at the input while advance is low; unknown opcodes forward nothing
`timescale 1ns/100ps
`default_nettype none

module exStage1 (
	input wire clock,
	input wire rst,
	input wire advance,
	input wire execTypes::microOp op,
	input wire [63:0] valRs,
	input wire [63:0] valRm,
	input wire [63:0] aluResult,	// From the combinational ALU
	input wire [1:0] aluFlags,
	output execTypes::ex1Bundle ex1State
);

	execTypes::writeBack defWb;
	logic [63:0] immExt;

	assign immExt = {{31{op.imm[32]}}, op.imm};	// 33 to 64 bits

	// Simple results that finish in EX1
	always_comb begin
		defWb.regId = regNames::GR_ZZR;	// Nothing by default
		defWb.value = '0;
		case (op.cmd)
			execTypes::MOV_IR: begin
				defWb.regId = op.idRm;
				defWb.value = immExt;
			end
			execTypes::LEA_MR: begin
				defWb.regId = op.idRm;
				defWb.value = valRm + immExt;	// Address-like add
			end
			default: begin
			end
		endcase
	end

	// EX1 register
	always_ff @(posedge clock) begin
		if (rst) begin
			ex1State.op.cmd <= execTypes::NOP;
			ex1State.wb.regId <= regNames::GR_ZZR;
		end else if (advance) begin
			ex1State.op <= op;
			ex1State.wb <= defWb;
			ex1State.aluResult <= aluResult;	// Used by ALU3 in EX2
			ex1State.aluFlags <= aluFlags;
			ex1State.valRs <= valRs;
		end
	end

endmodule

`default_nettype wire

// File: source/exStage2.sv
// holdCycles must be 1 to 255; flush kills the EX2 op entirely, a flushed SLEEP raises no hold
`timescale 1ns/100ps
`default_nettype none

module exStage2 #(
	parameter int holdCycles = 15	// SLEEP length in cycles
) (
	input wire clock,
	input wire rst,
	input wire execTypes::ex1Bundle ex1State,
	input wire [63:0] mulProduct,
	input wire braFlush,	// Level, applies to the op now in EX2
	input wire [63:0] srIn,	// Status load value during reset
	output execTypes::writeBack wb,
	output logic [63:0] statusReg,
	output logic exHold
);

	execTypes::ex1Bundle ex2State;	// EX2 register
	logic [63:0] mulHeld;	// Product kept in step with ex2State
	logic [7:0] holdCount;	// Saturating
	logic sleepOp;
	execTypes::uCmd effCmd;
	execTypes::writeBack nextWb;
	logic [63:0] nextSr;

	always_comb begin
		effCmd = braFlush ? execTypes::NOP : ex2State.op.cmd;	// Flush drops the op
		nextWb = ex2State.wb;	// Forward EX1's result
		nextSr = statusReg;
		sleepOp = 1'b0;

		case (effCmd)
			execTypes::ALU3: begin
				nextWb.regId = ex2State.op.idRm;	// Deferred ALU result
				nextWb.value = ex2State.aluResult;
				nextSr[regNames::SR_T] = ex2State.aluFlags[regNames::SR_T];
				nextSr[regNames::SR_S] = ex2State.aluFlags[regNames::SR_S];
			end
			execTypes::ALUCMP: begin
				nextSr[regNames::SR_T] = ex2State.aluFlags[regNames::SR_T];
				nextSr[regNames::SR_S] = ex2State.aluFlags[regNames::SR_S];
			end
			execTypes::MULW3: begin
				nextWb.regId = ex2State.op.idRm;
				nextWb.value = mulHeld;
			end
			execTypes::JMP: begin
				// Return through LR or DHR brings the saved flags back
				if ((ex2State.op.idRs == regNames::GR_LR) ||
					(ex2State.op.idRs == regNames::GR_DHR)) begin
					nextSr[regNames::SR_T] = ex2State.valRs[48];
					nextSr[regNames::SR_S] = ex2State.valRs[49];
				end
			end
			execTypes::OP_IXT: begin
				sleepOp = (ex2State.op.ixt == execTypes::IXT_SLEEP);
			end
			default: begin
			end
		endcase

		exHold = sleepOp && (holdCount < holdCycles);

		if (braFlush || exHold)
			nextWb.regId = regNames::GR_ZZR;	// No write, no duplicate
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ex2State.op.cmd <= execTypes::NOP;
			ex2State.wb.regId <= regNames::GR_ZZR;
		end else if (!exHold) begin
			ex2State <= ex1State;
			mulHeld <= mulProduct;
		end
	end

	// Outputs and status
	always_ff @(posedge clock) begin
		if (rst) begin
			wb.regId <= regNames::GR_ZZR;
			statusReg <= srIn;
		end else begin
			wb <= nextWb;
			statusReg <= nextSr;
		end
	end

	// Hold counter, cleared as soon as the hold drops
	always_ff @(posedge clock) begin
		if (rst)
			holdCount <= '0;
		else if (exHold) begin
			if (holdCount != 8'hFF)
				holdCount <= holdCount + 8'd1;
		end else
			holdCount <= '0;
	end

endmodule

`default_nettype wire

// File: source/execUnit.sv
// Three-cycle latency with no handshake; the source holds op and operands stable while exHold is high
`timescale 1ns/100ps
`default_nettype none

module execUnit #(
	parameter int holdCycles = 15	// 1 to 255
) (
	input wire clock,
	input wire rst,
	input wire execTypes::microOp op,
	input wire [63:0] valRs,
	input wire [63:0] valRt,
	input wire [63:0] valRm,
	input wire braFlush,
	input wire [63:0] srIn,
	output execTypes::writeBack wb,
	output logic [63:0] statusReg,
	output logic exHold
);

	logic advance;
	logic [63:0] aluResult;
	logic [1:0] aluFlags;
	logic [63:0] mulProduct;
	execTypes::ex1Bundle ex1State;

	assign advance = ~exHold;	// Whole pipe freezes on a hold

	exAlu alu (
		.ixt(op.ixt),
		.a(valRs),
		.b(valRt),
		.result(aluResult),
		.flags(aluFlags)
	);

	// Low words only
	exMulWord mul (
		.clock(clock),
		.rst(rst),
		.advance(advance),
		.a(valRs[31:0]),
		.b(valRt[31:0]),
		.product(mulProduct)
	);

	exStage1 ex1 (
		.clock(clock),
		.rst(rst),
		.advance(advance),
		.op(op),
		.valRs(valRs),
		.valRm(valRm),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.ex1State(ex1State)
	);

	exStage2 #(
		.holdCycles(holdCycles)
	) ex2 (
		.clock(clock),
		.rst(rst),
		.ex1State(ex1State),
		.mulProduct(mulProduct),
		.braFlush(braFlush),
		.srIn(srIn),
		.wb(wb),
		.statusReg(statusReg),
		.exHold(exHold)
	);

endmodule

`default_nettype wire

// File: bench/execUnitTb.sv
// Runs with holdCycles at 4 and fixed-seed operands; expected values come from the execute rules
`timescale 1ns/100ps
`default_nettype none

module execUnitTb;

	localparam int holdLen = 4;
	localparam int numRows = 18;
	localparam int resetCycles = 4;
	localparam int watchCycles = numRows * (holdLen + 8) + resetCycles;

	typedef struct packed {
		execTypes::microOp op;
		execTypes::microOp behind;	// Sent right after op, NOP unless testing overlap
		logic [63:0] valRs;
		logic [63:0] valRt;
		logic [63:0] valRm;
		logic flush;	// Raise braFlush in the op's EX2 cycle
		execTypes::writeBack expWb;
		logic [1:0] expFlags;	// {S, T}
		logic [7:0] expHold;
	} rowEntry;

	logic clock = 1'b0;
	logic rst;
	execTypes::microOp op;
	logic [63:0] valRs;
	logic [63:0] valRt;
	logic [63:0] valRm;
	logic braFlush;
	logic [63:0] srIn;
	execTypes::writeBack wb;
	logic [63:0] statusReg;
	logic exHold;
	logic [1:0] srFlags;

	rowEntry tab [numRows];
	int fillCount;
	logic [1:0] flagModel;	// Flags as the rules predict
	int errCount;
	int rowFails;

	assign srFlags = {statusReg[regNames::SR_S], statusReg[regNames::SR_T]};

	execUnit #(
		.holdCycles(holdLen)
	) dut (
		.clock(clock),
		.rst(rst),
		.op(op),
		.valRs(valRs),
		.valRt(valRt),
		.valRm(valRm),
		.braFlush(braFlush),
		.srIn(srIn),
		.wb(wb),
		.statusReg(statusReg),
		.exHold(exHold)
	);

	always #5 clock = ~clock;	// 10 ns period

	// ALU result and flag rules
	task automatic aluExpect(input execTypes::uIxt ixt, input logic [63:0] a, input logic [63:0] b,
			output logic [63:0] res, output logic [1:0] fl);
		res = 64'h0;
		fl = 2'b00;
		case (ixt)
			execTypes::ADD: begin
				res = a + b;
				fl[regNames::SR_T] = (res < a);	// Wrapped, so carry out
				fl[regNames::SR_S] = res[63];
			end
			execTypes::SUB: begin
				res = a - b;
				fl[regNames::SR_T] = (a < b);	// Borrow
				fl[regNames::SR_S] = res[63];
			end
			execTypes::AND: res = a & b;
			execTypes::OR: res = a | b;
			execTypes::XOR: res = a ^ b;
			execTypes::CMPEQ: fl[regNames::SR_T] = (a == b);
			execTypes::CMPGT: fl[regNames::SR_T] = ($signed(a) > $signed(b));
			default: ;
		endcase
		if ((ixt == execTypes::AND) || (ixt == execTypes::OR) || (ixt == execTypes::XOR))
			fl[regNames::SR_S] = res[63];	// T stays clear
	endtask

	// Appends one row with random operands and its expected outcome
	task automatic addRow(input execTypes::uCmd cmd, input execTypes::uIxt ixt,
			input regNames::gprId idRs, input logic flush, input logic equalOps,
			input execTypes::uCmd behindCmd);
		rowEntry r;
		logic [63:0] res;
		logic [1:0] fl;
		logic [1:0] newFlags;
		logic signed [63:0] immExt;
		logic signed [63:0] mulA;
		logic signed [63:0] mulB;
		r = '0;
		r.op.cmd = cmd;
		r.op.ixt = ixt;
		r.op.idRs = idRs;
		r.op.idRt = 6'($urandom_range(31, 0));
		r.op.idRm = 6'(fillCount + 2);	// Never the zero register
		r.op.imm = {1'($urandom_range(1, 0)), $urandom};
		r.behind.cmd = behindCmd;
		r.behind.idRm = 6'h30;
		r.behind.imm = 33'h0_0000_5a5a;
		r.valRs = {$urandom, $urandom};
		if (cmd == execTypes::JMP)
			r.valRs[49:48] = ~flagModel;	// Saved flags differ from the live ones
		r.valRt = equalOps ? r.valRs : {$urandom, $urandom};
		r.valRm = {$urandom, $urandom};
		r.flush = flush;
		r.expWb.regId = regNames::GR_ZZR;
		aluExpect(ixt, r.valRs, r.valRt, res, fl);
		immExt = $signed(r.op.imm);	// 33 bits sign-extended
		mulA = $signed(r.valRs[31:0]);
		mulB = $signed(r.valRt[31:0]);
		newFlags = flagModel;
		case (cmd)
			execTypes::ALU3: begin
				r.expWb = {r.op.idRm, res};
				newFlags = fl;
			end
			execTypes::ALUCMP: newFlags = fl;	// Flags only
			execTypes::MOV_IR: r.expWb = {r.op.idRm, immExt};
			execTypes::LEA_MR: r.expWb = {r.op.idRm, r.valRm + immExt};
			execTypes::MULW3: r.expWb = {r.op.idRm, mulA * mulB};
			execTypes::JMP: begin
				if ((idRs == regNames::GR_LR) || (idRs == regNames::GR_DHR))
					newFlags = {r.valRs[49], r.valRs[48]};	// Saved S and T
			end
			execTypes::OP_IXT: r.expHold = (ixt == execTypes::IXT_SLEEP) ? 8'(holdLen) : 8'd0;
			default: ;
		endcase
		if (flush)
			r.expWb.regId = regNames::GR_ZZR;	// Killed, flags untouched
		r.expFlags = flush ? flagModel : newFlags;
		flagModel = r.expFlags;
		tab[fillCount] = r;
		fillCount++;
	endtask

	task automatic compareWb(input execTypes::writeBack got, input execTypes::writeBack exp);
		if (got.regId !== exp.regId) begin
			$display("FAILED wb.regId: got 0x%h, expected 0x%h", got.regId, exp.regId);
			errCount++;
		end else if ((exp.regId != regNames::GR_ZZR) && (got.value !== exp.value)) begin
			$display("FAILED wb.value: got 0x%h, expected 0x%h", got.value, exp.value);
			errCount++;
		end
	endtask

	task automatic compareFlags(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("FAILED statusReg flags: got 0x%h, expected 0x%h", got, exp);
			errCount++;
		end
	endtask

	task automatic compareHold(input int got, input int exp);
		if (got != exp) begin
			$display("FAILED exHold cycles: got 0x%h, expected 0x%h", got, exp);
			errCount++;
		end
	endtask

	task automatic driveOp(input execTypes::microOp uOp, input logic [63:0] a,
			input logic [63:0] b, input logic [63:0] m);
		op = uOp;
		valRs = a;
		valRt = b;
		valRm = m;
	endtask

	// Entered and left on a falling edge
	task automatic runRow(input int i);
		int holdSeen;
		int errBefore;
		logic isSleep;
		execTypes::uCmd cmdName;
		holdSeen = 0;
		errBefore = errCount;
		cmdName = tab[i].op.cmd;
		isSleep = (tab[i].op.cmd == execTypes::OP_IXT) && (tab[i].op.ixt == execTypes::IXT_SLEEP);
		driveOp(tab[i].op, tab[i].valRs, tab[i].valRt, tab[i].valRm);
		while (exHold) begin	// Op waits at the input
			holdSeen++;
			@(negedge clock);
		end
		@(negedge clock);	// Op in EX1
		// Different operands follow the op
		driveOp(tab[i].behind, ~tab[i].valRs, ~tab[i].valRt, tab[i].valRm);
		@(negedge clock);	// Op in EX2
		compareWb(wb, {regNames::GR_ZZR, 64'h0});	// Nothing written yet
		if (isSleep && (i + 1 < numRows))
			driveOp(tab[i + 1].op, tab[i + 1].valRs, tab[i + 1].valRt, tab[i + 1].valRm);
		else
			driveOp('0, '0, '0, '0);
		if (tab[i].flush)
			braFlush = 1'b1;
		if (isSleep) begin
			while (exHold) begin	// Next op held at the input meanwhile
				holdSeen++;
				@(negedge clock);
			end
		end else begin
			@(negedge clock);	// Result registered
			braFlush = 1'b0;
		end
		compareWb(wb, tab[i].expWb);
		compareFlags(srFlags, tab[i].expFlags);
		compareHold(holdSeen, int'(tab[i].expHold));
		if (errCount == errBefore)
			$display("row %0d %s: ok", i, cmdName.name());
		else begin
			$display("row %0d %s: %0d mismatches", i, cmdName.name(), errCount - errBefore);
			rowFails++;
		end
	endtask

	initial begin
		#(watchCycles * 10);
		$display("watchdog expired before all rows finished");
		$display("test failed");
		$finish;
	end

	initial begin
		int seedInit;
		seedInit = $urandom(32'hc730_7e04);
		rst = 1'b1;
		driveOp('0, '0, '0, '0);
		braFlush = 1'b0;
		srIn = '0;
		errCount = 0;
		rowFails = 0;
		fillCount = 0;
		flagModel = 2'b00;	// Loaded from srIn in reset
		addRow(execTypes::ALU3, execTypes::ADD, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::SUB, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::AND, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::OR, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::XOR, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::CMPEQ, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::CMPGT, 6'h04, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALUCMP, execTypes::CMPEQ, 6'h05, 1'b0, 1'b1, execTypes::NOP);
		addRow(execTypes::ALUCMP, execTypes::CMPGT, 6'h05, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::MOV_IR, execTypes::ADD, 6'h06, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::LEA_MR, execTypes::ADD, 6'h06, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::MULW3, execTypes::ADD, 6'h07, 1'b0, 1'b0, execTypes::MOV_IR);
		addRow(execTypes::MULW3, execTypes::ADD, 6'h07, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::SUB, 6'h08, 1'b1, 1'b0, execTypes::NOP);
		addRow(execTypes::JMP, execTypes::ADD, regNames::GR_LR, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::JMP, execTypes::ADD, 6'h09, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::OP_IXT, execTypes::IXT_SLEEP, 6'h0a, 1'b0, 1'b0, execTypes::NOP);
		addRow(execTypes::ALU3, execTypes::ADD, 6'h0b, 1'b0, 1'b0, execTypes::NOP);
		repeat (resetCycles) @(negedge clock);
		rst = 1'b0;
		compareWb(wb, {regNames::GR_ZZR, 64'h0});	// State left by reset
		compareFlags(srFlags, 2'b00);
		if (exHold !== 1'b0) begin
			$display("exHold is not low after reset");
			errCount++;
		end
		for (int i = 0; i < numRows; i++)
			runRow(i);
		$display("rows run %0d, rows failed %0d, mismatches %0d", numRows, rowFails, errCount);
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
source/regNames.sv
source/execTypes.sv
source/exAlu.sv
source/exMulWord.sv
source/exStage1.sv
source/exStage2.sv
source/execUnit.sv
bench/execUnitTb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  # Packages first, execTypes uses regNames
  - source/regNames.sv
  - source/execTypes.sv
  - source/exAlu.sv
  - source/exMulWord.sv
  - source/exStage1.sv
  - source/exStage2.sv
  - source/execUnit.sv
  - target: simulation
    files:
      - bench/execUnitTb.sv
